/* rtl/rename_pkg.sv */
/*
 * shared widths and bundle structs for the rename stage
 * rnid and ready fields of the input bundle are ignored
 */
package rename_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int DISP_SIZE    = 2;
  localparam int NUM_LOG_REGS = 32;
  localparam int RNID_W       = 6;
  localparam int TGT_BUS_SIZE = 2;
  localparam int NUM_SRC      = 2;
  localparam int REGIDX_W     = $clog2(NUM_LOG_REGS);

  // count of slots per bundle, 0 to DISP_SIZE
  localparam int DISP_CNT_W = $clog2(DISP_SIZE + 1);

  typedef logic [5:0] cmt_id_t;

  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_type_t;

  // --------------------------------------------------
  // operand and slot structs
  // --------------------------------------------------
  typedef struct packed {
    logic                valid;
    reg_type_t           typ;
    logic [REGIDX_W-1:0] regidx;
    logic [RNID_W-1:0]   rnid;
    logic                ready;
  } reg_src_t;

  typedef struct packed {
    logic                valid;
    reg_type_t           typ;
    logic [REGIDX_W-1:0] regidx;
    logic [RNID_W-1:0]   rnid;
  } reg_dst_t;

  typedef struct packed {
    logic                      valid;
    logic [31:0]               inst;
    reg_dst_t                  wr_reg;
    reg_src_t [NUM_SRC-1:0]    rd_regs;
  } disp_t;

  // --------------------------------------------------
  // bundles, write-back and commit
  // --------------------------------------------------
  typedef struct packed {
    logic [31:0]             pc_addr;
    logic                    is_br_included;
    disp_t [DISP_SIZE-1:0]   inst;
  } ibuf_pkt_t;

  typedef struct packed {
    logic [31:0]             pc_addr;
    logic                    is_br_included;
    cmt_id_t                 cmt_id;
    disp_t [DISP_SIZE-1:0]   inst;
  } rn_pkt_t;

  typedef struct packed {
    logic              valid;
    reg_type_t         rd_type;
    logic [RNID_W-1:0] rd_rnid;
  } phy_wr_t;

  // entry rnid is the new mapping of the committed destination
  typedef struct packed {
    logic                     valid;
    reg_dst_t [DISP_SIZE-1:0] entry;
  } commit_t;

endpackage

/* rtl/rename_freelist.sv */
/*
 * FIFO of free physical IDs, PHY_REGS-32 entries, reset to 32 upward
 * flush rewinds the head to the committed head
 */
`timescale 1ns/1ps

module rename_freelist #(
  parameter int PHY_REGS = 48
) (
  input  logic                                                    i_clk,
  input  logic                                                    i_reset_n,
  input  logic [rename_pkg::DISP_SIZE-1:0]                        i_alloc_req,
  input  logic [rename_pkg::DISP_SIZE-1:0]                        i_push_valid,
  input  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0] i_push_rnid,
  input  logic [rename_pkg::DISP_CNT_W-1:0]                       i_commit_cnt,
  input  logic                                                    i_flush,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0] o_alloc_rnid,
  output logic                                                    o_ready
);
  import rename_pkg::*;

  localparam int FL_SIZE = PHY_REGS - NUM_LOG_REGS;
  localparam int PTR_W   = $clog2(FL_SIZE);
  localparam int CNT_W   = $clog2(FL_SIZE + 1);

  logic [RNID_W-1:0]     r_fifo [FL_SIZE];
  logic [PTR_W-1:0]      r_head;
  logic [PTR_W-1:0]      r_cmt_head;
  logic [PTR_W-1:0]      r_tail;
  logic [CNT_W-1:0]      r_count;
  logic [PTR_W-1:0]      w_push_idx [DISP_SIZE];
  logic [DISP_CNT_W-1:0] w_alloc_cnt;
  logic [DISP_CNT_W-1:0] w_push_cnt;
  logic [PTR_W-1:0]      w_cmt_head_next;

  // pointer increment with wrap, n never exceeds FL_SIZE
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr, input int n);
    int sum;
    sum = int'(ptr) + n;
    if (sum >= FL_SIZE) begin
      sum = sum - FL_SIZE;
    end
    return PTR_W'(sum);
  endfunction

  // lower slot takes the older entry
  always_comb begin
    int alloc_ofs;
    int push_ofs;
    alloc_ofs = 0;
    push_ofs  = 0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_alloc_rnid[d] = r_fifo[ptr_add(r_head, alloc_ofs)];
      w_push_idx[d]   = ptr_add(r_tail, push_ofs);
      alloc_ofs += int'(i_alloc_req[d]);
      push_ofs  += int'(i_push_valid[d]);
    end
    w_alloc_cnt = DISP_CNT_W'(alloc_ofs);
    w_push_cnt  = DISP_CNT_W'(push_ofs);
  end

  assign w_cmt_head_next = ptr_add(r_cmt_head, int'(i_commit_cnt));

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < FL_SIZE; i++) begin
        r_fifo[i] <= RNID_W'(NUM_LOG_REGS + i);
      end
      r_head      <= '0;
      r_cmt_head  <= '0;
      r_tail      <= '0;
      r_count     <= CNT_W'(FL_SIZE);
    end else begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_push_valid[d]) begin
          r_fifo[w_push_idx[d]] <= i_push_rnid[d];
        end
      end
      r_tail      <= ptr_add(r_tail, int'(w_push_cnt));
      r_cmt_head  <= w_cmt_head_next;
      if (i_flush) begin
        // committed head to tail always spans the whole buffer
        r_head  <= w_cmt_head_next;
        r_count <= CNT_W'(FL_SIZE);
      end else begin
        r_head  <= ptr_add(r_head, int'(w_alloc_cnt));
        r_count <= r_count + CNT_W'(w_push_cnt) - CNT_W'(w_alloc_cnt);
      end
    end
  end

  assign o_ready = (r_count >= CNT_W'(DISP_SIZE));

endmodule

/* rtl/rename_map.sv */
/*
 * speculative and commit maps for one register class, identity at reset
 * GPR x0 is never renamed or committed
 */
`timescale 1ns/1ps

module rename_map #(
  parameter rename_pkg::reg_type_t REG_TYPE = rename_pkg::GPR
) (
  input  logic                                               i_clk,
  input  logic                                               i_reset_n,
  input  logic                                               i_fire,
  input  rename_pkg::disp_t [rename_pkg::DISP_SIZE-1:0]      i_bundle,
  input  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0] i_alloc_rnid,
  input  rename_pkg::commit_t                                i_commit,
  input  logic                                               i_flush,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0][rename_pkg::RNID_W-1:0]
                                                             o_src_rnid,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] o_src_bypassed,
  output logic [rename_pkg::DISP_SIZE-1:0]                   o_alloc_req,
  output logic [rename_pkg::DISP_SIZE-1:0]                   o_free_valid,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0] o_free_rnid,
  output logic [rename_pkg::DISP_CNT_W-1:0]                  o_commit_cnt
);
  import rename_pkg::*;

  logic [RNID_W-1:0]    r_spec_map     [NUM_LOG_REGS];
  logic [RNID_W-1:0]    r_cmt_map      [NUM_LOG_REGS];
  logic [RNID_W-1:0]    w_cmt_map_next [NUM_LOG_REGS];
  logic [DISP_SIZE-1:0] w_need_dst;

  function automatic logic is_renamed(input reg_dst_t dst);
    return dst.valid && (dst.typ == REG_TYPE) &&
           !((REG_TYPE == GPR) && (dst.regidx == '0));
  endfunction

  // --------------------------------------------------
  // source lookup with intra-bundle bypass
  // --------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_need_dst[d] = is_renamed(i_bundle[d].wr_reg);
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      for (int s = 0; s < NUM_SRC; s++) begin
        o_src_rnid[d][s]     = r_spec_map[i_bundle[d].rd_regs[s].regidx];
        o_src_bypassed[d][s] = 1'b0;
        // latest earlier writer wins
        for (int e = 0; e < d; e++) begin
          if (w_need_dst[e] && (i_bundle[d].rd_regs[s].typ == REG_TYPE) &&
              (i_bundle[e].wr_reg.regidx == i_bundle[d].rd_regs[s].regidx)) begin
            o_src_rnid[d][s]     = i_alloc_rnid[e];
            o_src_bypassed[d][s] = 1'b1;
          end
        end
      end
    end
  end

  assign o_alloc_req = w_need_dst & {DISP_SIZE{i_fire}};

  // --------------------------------------------------
  // commit map update and displaced IDs
  // --------------------------------------------------
  always_comb begin
    int cnt;
    cnt = 0;
    for (int r = 0; r < NUM_LOG_REGS; r++) begin
      w_cmt_map_next[r] = r_cmt_map[r];
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_free_valid[d] = i_commit.valid && is_renamed(i_commit.entry[d]);
      // sees an earlier entry of the same group to the same register
      o_free_rnid[d]  = w_cmt_map_next[i_commit.entry[d].regidx];
      if (o_free_valid[d]) begin
        w_cmt_map_next[i_commit.entry[d].regidx] = i_commit.entry[d].rnid;
        cnt++;
      end
    end
    o_commit_cnt = DISP_CNT_W'(cnt);
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < NUM_LOG_REGS; r++) begin
        r_spec_map[r] <= RNID_W'(r);
        r_cmt_map[r]  <= RNID_W'(r);
      end
    end else begin
      for (int r = 0; r < NUM_LOG_REGS; r++) begin
        r_cmt_map[r] <= w_cmt_map_next[r];
      end
      if (i_flush) begin
        for (int r = 0; r < NUM_LOG_REGS; r++) begin
          r_spec_map[r] <= w_cmt_map_next[r];
        end
      end else begin
        for (int d = 0; d < DISP_SIZE; d++) begin
          if (o_alloc_req[d]) begin
            r_spec_map[i_bundle[d].wr_reg.regidx] <= i_alloc_rnid[d];
          end
        end
      end
    end
  end

endmodule

/* rtl/rename_inflight.sv */
/*
 * one ready bit per physical register of a class
 * write-back ports must already be filtered to this class
 */
`timescale 1ns/1ps

module rename_inflight #(
  parameter int PHY_REGS = 48
) (
  input  logic                                                    i_clk,
  input  logic                                                    i_reset_n,
  input  logic [rename_pkg::DISP_SIZE-1:0]                        i_alloc_valid,
  input  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0] i_alloc_rnid,
  input  rename_pkg::phy_wr_t [rename_pkg::TGT_BUS_SIZE-1:0]      i_wr,
  input  logic                                                    i_flush,
  input  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0][rename_pkg::RNID_W-1:0]
                                                                  i_lookup_rnid,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::NUM_SRC-1:0] o_lookup_ready
);
  import rename_pkg::*;

  logic [PHY_REGS-1:0] r_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else if (i_flush) begin
      r_ready <= '1;
    end else begin
      for (int t = 0; t < TGT_BUS_SIZE; t++) begin
        if (i_wr[t].valid) begin
          r_ready[i_wr[t].rd_rnid] <= 1'b1;
        end
      end
      // a new allocation is pending again
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_alloc_valid[d]) begin
          r_ready[i_alloc_rnid[d]] <= 1'b0;
        end
      end
    end
  end

  // same-cycle write-back counts as ready
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      for (int s = 0; s < NUM_SRC; s++) begin
        o_lookup_ready[d][s] = r_ready[i_lookup_rnid[d][s]];
        for (int t = 0; t < TGT_BUS_SIZE; t++) begin
          if (i_wr[t].valid && (i_wr[t].rd_rnid == i_lookup_rnid[d][s])) begin
            o_lookup_ready[d][s] = 1'b1;
          end
        end
      end
    end
  end

endmodule

/* rtl/rename_sub.sv */
/*
 * rename of one register class; fields of other classes come out zero
 * valid and inst of each slot are left to the top level
 */
`timescale 1ns/1ps

module rename_sub #(
  parameter rename_pkg::reg_type_t REG_TYPE = rename_pkg::GPR,
  parameter int                    PHY_REGS = 48
) (
  input  logic                                              i_clk,
  input  logic                                              i_reset_n,
  input  logic                                              i_fire,
  input  rename_pkg::disp_t [rename_pkg::DISP_SIZE-1:0]     i_bundle,
  input  rename_pkg::phy_wr_t [rename_pkg::TGT_BUS_SIZE-1:0] i_phy_wr,
  input  rename_pkg::commit_t                               i_commit,
  input  logic                                              i_flush,
  output logic                                              o_freelist_ready,
  output rename_pkg::disp_t [rename_pkg::DISP_SIZE-1:0]     o_disp_inst
);
  import rename_pkg::*;

  phy_wr_t [TGT_BUS_SIZE-1:0]                          w_wr;
  logic [DISP_SIZE-1:0]                                w_alloc_req;
  logic [DISP_SIZE-1:0][RNID_W-1:0]                    w_alloc_rnid;
  logic [DISP_SIZE-1:0]                                w_free_valid;
  logic [DISP_SIZE-1:0][RNID_W-1:0]                    w_free_rnid;
  logic [DISP_CNT_W-1:0]                               w_commit_cnt;
  logic [DISP_SIZE-1:0][NUM_SRC-1:0][RNID_W-1:0]       w_src_rnid;
  logic [DISP_SIZE-1:0][NUM_SRC-1:0]                   w_src_bypassed;
  logic [DISP_SIZE-1:0][NUM_SRC-1:0]                   w_src_ready;

  // keep only write-backs of this class
  always_comb begin
    for (int t = 0; t < TGT_BUS_SIZE; t++) begin
      w_wr[t]       = i_phy_wr[t];
      w_wr[t].valid = i_phy_wr[t].valid && (i_phy_wr[t].rd_type == REG_TYPE);
    end
  end

  rename_freelist #(.PHY_REGS(PHY_REGS)) u_freelist (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_alloc_req  (w_alloc_req),
    .i_push_valid (w_free_valid),
    .i_push_rnid  (w_free_rnid),
    .i_commit_cnt (w_commit_cnt),
    .i_flush      (i_flush),
    .o_alloc_rnid (w_alloc_rnid),
    .o_ready      (o_freelist_ready)
  );

  rename_map #(.REG_TYPE(REG_TYPE)) u_map (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_fire         (i_fire),
    .i_bundle       (i_bundle),
    .i_alloc_rnid   (w_alloc_rnid),
    .i_commit       (i_commit),
    .i_flush        (i_flush),
    .o_src_rnid     (w_src_rnid),
    .o_src_bypassed (w_src_bypassed),
    .o_alloc_req    (w_alloc_req),
    .o_free_valid   (w_free_valid),
    .o_free_rnid    (w_free_rnid),
    .o_commit_cnt   (w_commit_cnt)
  );

  rename_inflight #(.PHY_REGS(PHY_REGS)) u_inflight (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_alloc_valid  (w_alloc_req),
    .i_alloc_rnid   (w_alloc_rnid),
    .i_wr           (w_wr),
    .i_flush        (i_flush),
    .i_lookup_rnid  (w_src_rnid),
    .o_lookup_ready (w_src_ready)
  );

  // --------------------------------------------------
  // class fields of each slot
  // --------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_disp_inst[d] = '0;
      if (i_bundle[d].wr_reg.valid && (i_bundle[d].wr_reg.typ == REG_TYPE)) begin
        o_disp_inst[d].wr_reg.valid  = 1'b1;
        o_disp_inst[d].wr_reg.typ    = REG_TYPE;
        o_disp_inst[d].wr_reg.regidx = i_bundle[d].wr_reg.regidx;
        o_disp_inst[d].wr_reg.rnid   = w_alloc_req[d] ? w_alloc_rnid[d] : '0;
      end
      for (int s = 0; s < NUM_SRC; s++) begin
        if (i_bundle[d].rd_regs[s].valid && (i_bundle[d].rd_regs[s].typ == REG_TYPE)) begin
          o_disp_inst[d].rd_regs[s].valid  = 1'b1;
          o_disp_inst[d].rd_regs[s].typ    = REG_TYPE;
          o_disp_inst[d].rd_regs[s].regidx = i_bundle[d].rd_regs[s].regidx;
          o_disp_inst[d].rd_regs[s].rnid   = w_src_rnid[d][s];
          o_disp_inst[d].rd_regs[s].ready  = w_src_ready[d][s] & ~w_src_bypassed[d][s];
        end
      end
    end
  end

endmodule

/* rtl/rename_stage.sv */
/*
 * rename stage top: GPR and FPR rename, one-cycle output register
 * no output ready, the next stage always accepts
 */
`timescale 1ns/1ps

module rename_stage #(
  parameter int PHY_REGS = 48
) (
  input  logic                                               i_clk,
  input  logic                                               i_reset_n,
  input  logic                                               i_ibuf_valid,
  input  rename_pkg::ibuf_pkt_t                              i_ibuf_payload,
  output logic                                               o_ibuf_ready,
  input  logic                                               i_resource_ok,
  input  rename_pkg::cmt_id_t                                i_new_cmt_id,
  input  rename_pkg::phy_wr_t [rename_pkg::TGT_BUS_SIZE-1:0] i_phy_wr,
  input  rename_pkg::commit_t                                i_commit,
  input  logic                                               i_flush,
  output logic                                               o_rn_valid,
  output rename_pkg::rn_pkt_t                                o_rn_payload
);
  import rename_pkg::*;

  logic                  w_gpr_ready;
  logic                  w_fpr_ready;
  logic                  w_fire;
  disp_t [DISP_SIZE-1:0] w_gpr_inst;
  disp_t [DISP_SIZE-1:0] w_fpr_inst;
  disp_t [DISP_SIZE-1:0] w_merge_inst;
  logic                  r_rn_valid;
  logic [31:0]           r_pc_addr;
  logic                  r_is_br_included;
  disp_t [DISP_SIZE-1:0] r_inst;

  assign o_ibuf_ready = i_resource_ok & w_gpr_ready & w_fpr_ready & ~i_flush;
  assign w_fire       = i_ibuf_valid & o_ibuf_ready;

  rename_sub #(.REG_TYPE(GPR), .PHY_REGS(PHY_REGS)) u_gpr_rename (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_fire           (w_fire),
    .i_bundle         (i_ibuf_payload.inst),
    .i_phy_wr         (i_phy_wr),
    .i_commit         (i_commit),
    .i_flush          (i_flush),
    .o_freelist_ready (w_gpr_ready),
    .o_disp_inst      (w_gpr_inst)
  );

  rename_sub #(.REG_TYPE(FPR), .PHY_REGS(PHY_REGS)) u_fpr_rename (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_fire           (w_fire),
    .i_bundle         (i_ibuf_payload.inst),
    .i_phy_wr         (i_phy_wr),
    .i_commit         (i_commit),
    .i_flush          (i_flush),
    .o_freelist_ready (w_fpr_ready),
    .o_disp_inst      (w_fpr_inst)
  );

  // class fields are disjoint, so OR merges them
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_merge_inst[d]       = w_gpr_inst[d] | w_fpr_inst[d];
      w_merge_inst[d].valid = i_ibuf_payload.inst[d].valid;
      w_merge_inst[d].inst  = i_ibuf_payload.inst[d].inst;
    end
  end

  // --------------------------------------------------
  // output register
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rn_valid <= 1'b0;
    end else begin
      r_rn_valid <= w_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      r_pc_addr        <= i_ibuf_payload.pc_addr;
      r_is_br_included <= i_ibuf_payload.is_br_included;
      r_inst           <= w_merge_inst;
    end
  end

  assign o_rn_valid = r_rn_valid;

  // cmt_id is taken live at the output
  always_comb begin
    o_rn_payload.pc_addr        = r_pc_addr;
    o_rn_payload.is_br_included = r_is_br_included;
    o_rn_payload.cmt_id         = i_new_cmt_id;
    o_rn_payload.inst           = r_inst;
  end

endmodule

/* test/rename_clk_gen.sv */
/*
 * free-running clock and active-low reset, released on a falling edge
 */
`timescale 1ns/1ps

module rename_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // count rising edges, then release on the next falling edge
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

/* test/rename_stage_props.sv */
/*
 * handshake and output checks, bound into every rename_stage
 * fail_cnt lets the testbench see assertion failures
 */
`timescale 1ns/1ps

module rename_stage_props (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic                i_ibuf_valid,
  input logic                i_ibuf_ready,
  input logic                i_flush,
  input logic                i_rn_valid,
  input rename_pkg::rn_pkt_t i_rn_payload
);
  import rename_pkg::*;

  int cnt_reset;
  int cnt_flush;
  int cnt_follow;
  int cnt_dup;
  int fail_cnt;

  initial begin
    cnt_reset  = 0;
    cnt_flush  = 0;
    cnt_follow = 0;
    cnt_dup    = 0;
  end

  assign fail_cnt = cnt_reset + cnt_flush + cnt_follow + cnt_dup;

  // GPR x0 gets no physical register
  function automatic logic takes_rnid(input reg_dst_t dst);
    return dst.valid && !((dst.typ == GPR) && (dst.regidx == '0));
  endfunction

  idle_after_reset: assert property (@(posedge i_clk) $rose(i_reset_n) |-> !i_rn_valid)
    else begin
      $error("o_rn_valid high right after reset");
      cnt_reset++;
    end

  no_ready_in_flush: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_flush |-> !i_ibuf_ready)
    else begin
      $error("o_ibuf_ready high during flush");
      cnt_flush++;
    end

  valid_after_fire: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_rn_valid == $past(i_ibuf_valid && i_ibuf_ready))
    else begin
      $error("o_rn_valid does not follow fire by one cycle");
      cnt_follow++;
    end

  distinct_dst: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_rn_valid && takes_rnid(i_rn_payload.inst[0].wr_reg) &&
     takes_rnid(i_rn_payload.inst[1].wr_reg) &&
     (i_rn_payload.inst[0].wr_reg.typ == i_rn_payload.inst[1].wr_reg.typ))
    |-> (i_rn_payload.inst[0].wr_reg.rnid != i_rn_payload.inst[1].wr_reg.rnid))
    else begin
      $error("both slots got the same destination rnid");
      cnt_dup++;
    end

endmodule

/* test/rename_stage_tb.sv */
/*
 * random bundles, write-backs, in-order commits and two flushes
 * checked against a model of maps, free lists and ready bits
 */
`timescale 1ns/1ps

module rename_stage_tb;
  import rename_pkg::*;

  localparam int PHY_REGS   = 48;
  localparam int RUN_CYCLES = 1200;
  // three times the run covers reset and drain
  localparam int MAX_CYCLES = 3 * RUN_CYCLES + 400;
  localparam int FLUSH_AT_0 = 400;
  localparam int FLUSH_AT_1 = 850;

  logic                       clk;
  logic                       reset_n;
  logic                       ibuf_valid;
  ibuf_pkt_t                  ibuf_payload;
  logic                       ibuf_ready;
  logic                       resource_ok;
  cmt_id_t                    new_cmt_id;
  phy_wr_t [TGT_BUS_SIZE-1:0] phy_wr;
  commit_t                    commit;
  logic                       flush;
  logic                       rn_valid;
  rn_pkt_t                    rn_payload;

  // model state, index 0 is GPR and 1 is FPR
  int        spec_map [2][NUM_LOG_REGS];
  int        cmt_map  [2][NUM_LOG_REGS];
  bit        ready_bit[2][PHY_REGS];
  int        fl_q     [2][$];
  int        spec_ofs [2];
  commit_t   pend_cmt [$];
  phy_wr_t   wb_q     [$];
  int        wb_due   [$];
  rn_pkt_t   exp_pkt;
  bit        exp_valid;
  bit        exp_ready;
  bit        fire;
  int        cyc;
  int        total_cyc;
  int        err_value;
  int        err_handshake;
  logic [15:0] lfsr;

  rename_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clk_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  rename_stage #(.PHY_REGS(PHY_REGS)) rename_stage_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_ibuf_valid   (ibuf_valid),
    .i_ibuf_payload (ibuf_payload),
    .o_ibuf_ready   (ibuf_ready),
    .i_resource_ok  (resource_ok),
    .i_new_cmt_id   (new_cmt_id),
    .i_phy_wr       (phy_wr),
    .i_commit       (commit),
    .i_flush        (flush),
    .o_rn_valid     (rn_valid),
    .o_rn_payload   (rn_payload)
  );

  bind rename_stage rename_stage_props u_props (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ibuf_valid (i_ibuf_valid),
    .i_ibuf_ready (o_ibuf_ready),
    .i_flush      (i_flush),
    .i_rn_valid   (o_rn_valid),
    .i_rn_payload (o_rn_payload)
  );

  task automatic report_mismatch(input bit handshake, input string msg);
    if (handshake) err_handshake++;
    else err_value++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  function automatic bit needs_alloc(input reg_dst_t dst);
    return dst.valid && !((dst.typ == GPR) && (dst.regidx == '0));
  endfunction

  function automatic int free_count(input int c);
    return fl_q[c].size() - spec_ofs[c];
  endfunction

  // small register range so bypass and write-back hits are frequent
  function automatic disp_t rand_slot();
    disp_t s;
    s             = '0;
    s.valid       = 1'b1;
    s.inst        = rand_bits(32);
    s.wr_reg.valid  = (rand_bits(2) != '0);
    s.wr_reg.typ    = (rand_bits(1) != '0) ? FPR : GPR;
    s.wr_reg.regidx = REGIDX_W'(rand_bits(3));
    for (int i = 0; i < NUM_SRC; i++) begin
      s.rd_regs[i].valid  = (rand_bits(1) != '0);
      s.rd_regs[i].typ    = (rand_bits(1) != '0) ? FPR : GPR;
      s.rd_regs[i].regidx = REGIDX_W'(rand_bits(3));
    end
    return s;
  endfunction

  // --------------------------------------------------
  // model
  // --------------------------------------------------
  task automatic reset_model();
    for (int c = 0; c < 2; c++) begin
      for (int r = 0; r < NUM_LOG_REGS; r++) begin
        spec_map[c][r] = r;
        cmt_map[c][r]  = r;
      end
      for (int p = 0; p < PHY_REGS; p++) ready_bit[c][p] = 1'b1;
      fl_q[c].delete();
      for (int p = NUM_LOG_REGS; p < PHY_REGS; p++) fl_q[c].push_back(p);
      spec_ofs[c] = 0;
    end
  endtask

  task automatic rename_bundle();
    int      n_alloc [2];
    int      new_rn [DISP_SIZE];
    int      c;
    int      rn;
    bit      rdy;
    reg_dst_t dst;
    reg_src_t src;
    phy_wr_t wb;
    commit_t rec;
    n_alloc = '{0, 0};
    exp_pkt = '0;
    exp_pkt.pc_addr        = ibuf_payload.pc_addr;
    exp_pkt.is_br_included = ibuf_payload.is_br_included;
    for (int d = 0; d < DISP_SIZE; d++) begin
      exp_pkt.inst[d].valid = ibuf_payload.inst[d].valid;
      exp_pkt.inst[d].inst  = ibuf_payload.inst[d].inst;
      dst       = ibuf_payload.inst[d].wr_reg;
      new_rn[d] = -1;
      if (dst.valid) begin
        c = int'(dst.typ);
        exp_pkt.inst[d].wr_reg.valid  = 1'b1;
        exp_pkt.inst[d].wr_reg.typ    = dst.typ;
        exp_pkt.inst[d].wr_reg.regidx = dst.regidx;
        if (needs_alloc(dst)) begin
          new_rn[d] = fl_q[c][spec_ofs[c] + n_alloc[c]];
          n_alloc[c]++;
          exp_pkt.inst[d].wr_reg.rnid = RNID_W'(new_rn[d]);
        end
      end
      for (int s = 0; s < NUM_SRC; s++) begin
        src = ibuf_payload.inst[d].rd_regs[s];
        if (src.valid) begin
          c   = int'(src.typ);
          rn  = spec_map[c][src.regidx];
          rdy = ready_bit[c][rn];
          // an earlier slot of this bundle writes the register
          for (int e = 0; e < d; e++) begin
            if (new_rn[e] >= 0 && ibuf_payload.inst[e].wr_reg.typ == src.typ &&
                ibuf_payload.inst[e].wr_reg.regidx == src.regidx) begin
              rn  = new_rn[e];
              rdy = 1'b0;
            end
          end
          exp_pkt.inst[d].rd_regs[s].valid  = 1'b1;
          exp_pkt.inst[d].rd_regs[s].typ    = src.typ;
          exp_pkt.inst[d].rd_regs[s].regidx = src.regidx;
          exp_pkt.inst[d].rd_regs[s].rnid   = RNID_W'(rn);
          exp_pkt.inst[d].rd_regs[s].ready  = rdy;
        end
      end
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (new_rn[d] >= 0) begin
        dst = ibuf_payload.inst[d].wr_reg;
        c   = int'(dst.typ);
        spec_map[c][dst.regidx]  = new_rn[d];
        ready_bit[c][new_rn[d]] = 1'b0;
        wb.valid   = 1'b1;
        wb.rd_type = dst.typ;
        wb.rd_rnid = RNID_W'(new_rn[d]);
        wb_q.push_back(wb);
        wb_due.push_back(cyc + 1 + int'(rand_bits(3)));
      end
      rec.entry[d] = exp_pkt.inst[d].wr_reg;
    end
    rec.valid = 1'b1;
    pend_cmt.push_back(rec);
    spec_ofs[0] += n_alloc[0];
    spec_ofs[1] += n_alloc[1];
  endtask

  task automatic update_model();
    int c;
    int old;
    for (int t = 0; t < TGT_BUS_SIZE; t++) begin
      if (phy_wr[t].valid) ready_bit[int'(phy_wr[t].rd_type)][phy_wr[t].rd_rnid] = 1'b1;
    end
    if (fire) rename_bundle();
    exp_valid = fire;
    // displaced mapping goes to the tail, committed head moves on
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (commit.valid && needs_alloc(commit.entry[d])) begin
        c   = int'(commit.entry[d].typ);
        old = cmt_map[c][commit.entry[d].regidx];
        cmt_map[c][commit.entry[d].regidx] = int'(commit.entry[d].rnid);
        void'(fl_q[c].pop_front());
        fl_q[c].push_back(old);
        spec_ofs[c]--;
      end
    end
    if (flush) begin
      for (int k = 0; k < 2; k++) begin
        for (int r = 0; r < NUM_LOG_REGS; r++) spec_map[k][r] = cmt_map[k][r];
        for (int p = 0; p < PHY_REGS; p++) ready_bit[k][p] = 1'b1;
        spec_ofs[k] = 0;
      end
      pend_cmt.delete();
      wb_q.delete();
      wb_due.delete();
    end
  endtask

  // --------------------------------------------------
  // stimulus and checks
  // --------------------------------------------------
  task automatic drive_inputs();
    int n;
    ibuf_valid  = (rand_bits(2) != '0);
    resource_ok = (rand_bits(3) != '0);
    new_cmt_id  = cmt_id_t'(rand_bits(6));
    flush       = (cyc == FLUSH_AT_0) || (cyc == FLUSH_AT_1);
    ibuf_payload.pc_addr        = rand_bits(32);
    ibuf_payload.is_br_included = rand_bits(1) != '0;
    ibuf_payload.inst[0]        = rand_slot();
    ibuf_payload.inst[1]        = (rand_bits(3) != '0) ? rand_slot() : '0;
    // newest due write-backs first
    phy_wr = '0;
    n      = 0;
    for (int i = wb_q.size() - 1; i >= 0; i--) begin
      if (n < TGT_BUS_SIZE && wb_due[i] <= cyc) begin
        phy_wr[n] = wb_q[i];
        wb_q.delete(i);
        wb_due.delete(i);
        n++;
      end
    end
    commit = '0;
    if (pend_cmt.size() > 0 && rand_bits(2) == '0) commit = pend_cmt.pop_front();
  endtask

  task automatic check_output();
    assert (rn_valid == exp_valid)
      else report_mismatch(1'b1, $sformatf("o_rn_valid %0b, expected %0b", rn_valid, exp_valid));
    if (exp_valid && rn_valid) begin
      assert (rn_payload.pc_addr == exp_pkt.pc_addr &&
              rn_payload.is_br_included == exp_pkt.is_br_included)
        else report_mismatch(1'b0, $sformatf("pc %h br %0b, expected pc %h br %0b",
          rn_payload.pc_addr, rn_payload.is_br_included,
          exp_pkt.pc_addr, exp_pkt.is_br_included));
      assert (rn_payload.cmt_id == new_cmt_id)
        else report_mismatch(1'b0, $sformatf("cmt_id %0d, expected %0d",
          rn_payload.cmt_id, new_cmt_id));
      for (int d = 0; d < DISP_SIZE; d++) begin
        assert (rn_payload.inst[d] == exp_pkt.inst[d])
          else report_mismatch(1'b0, $sformatf("slot %0d is %h, expected %h",
            d, rn_payload.inst[d], exp_pkt.inst[d]));
      end
    end
  endtask

  ready_matches_model: assert property (@(posedge clk) disable iff (!reset_n)
    ibuf_ready == exp_ready)
    else report_mismatch(1'b1, $sformatf("o_ibuf_ready %0b, expected %0b",
      ibuf_ready, exp_ready));

  always @(posedge clk) begin
    total_cyc++;
    if (total_cyc >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    ibuf_valid    = 1'b0;
    ibuf_payload  = '0;
    resource_ok   = 1'b0;
    new_cmt_id    = '0;
    phy_wr        = '0;
    commit        = '0;
    flush         = 1'b0;
    exp_pkt       = '0;
    exp_valid     = 1'b0;
    exp_ready     = 1'b0;
    fire          = 1'b0;
    cyc           = 0;
    total_cyc     = 0;
    err_value     = 0;
    err_handshake = 0;
    lfsr          = 16'd31;
    reset_model();
    @(posedge reset_n);
    repeat (RUN_CYCLES) begin
      @(negedge clk);
      check_output();
      drive_inputs();
      exp_ready = resource_ok && !flush && (free_count(0) >= 2) && (free_count(1) >= 2);
      #1;
      fire = ibuf_valid && ibuf_ready;
      update_model();
      cyc++;
    end
    @(negedge clk);
    check_output();
    ibuf_valid  = 1'b0;
    resource_ok = 1'b0;
    phy_wr      = '0;
    commit      = '0;
    exp_ready   = 1'b0;
    repeat (2) @(negedge clk);
    $display("summary: %0d value errors, %0d handshake errors, %0d property failures",
      err_value, err_handshake, rename_stage_i.u_props.fail_cnt);
    if (err_value + err_handshake + rename_stage_i.u_props.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* rename_stage.f */
rtl/rename_pkg.sv
rtl/rename_freelist.sv
rtl/rename_map.sv
rtl/rename_inflight.sv
rtl/rename_sub.sv
rtl/rename_stage.sv
test/rename_clk_gen.sv
test/rename_stage_props.sv
test/rename_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rename_stage_tb \
  -f rename_stage.f -o rename_sim

out=$(./obj_dir/rename_sim +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
